// File: verification/aes_192_stimulus.txt
// Line 1 vector count, line 2 overflow burst length, both hex
// Then two lines per vector: 192-bit key, then plaintext and expected ciphertext
06
14
// FIPS-197 appendix C.2
000102030405060708090a0b0c0d0e0f1011121314151617
00112233445566778899aabbccddeeff dda97ca4864cdfe06eaf70a0ec0d7191
// SP 800-38A ECB-AES192 blocks 1 to 4
8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b
6bc1bee22e409f96e93d7e117393172a bd334f1d6e45f25ff712a214571fa5cc
8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b
ae2d8a571e03ac9c9eb76fac45af8e51 974104846d0ad3ad7734ecb3ecee4eef
8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b
30c81c46a35ce411e5fbc1191a0a52ef ef7afd2270e2e60adce0ba2face6444e
8e73b0f7da0e6452c810f32b809079e562f8ead2522c6b7b
f69f2445df4f9b17ad2b417be66c3710 9a4b41ba738d6c72fb16691603c18e0e
// AESAVS GFSbox, all zero key
000000000000000000000000000000000000000000000000
1b077a6af4b7f98229de786d7516b639 275cfc0413d8ccb70513c3859b1d0f72

// File: flist.f
verilog/aes_math_pkg.sv
verilog/aes_stream_pkg.sv
verilog/aes_key_expand_192.sv
verilog/aes_round.sv
verilog/aes_192_pipe.sv
verilog/aes_result_fifo.sv
verilog/aes_word_serializer.sv
verilog/aes_192_top.sv
verification/aes_192_tb.sv

// File: Bender.yml
package:
  name: aes_192

sources:
  - verilog/aes_math_pkg.sv
  - verilog/aes_stream_pkg.sv
  - verilog/aes_key_expand_192.sv
  - verilog/aes_round.sv
  - verilog/aes_192_pipe.sv
  - verilog/aes_result_fifo.sv
  - verilog/aes_word_serializer.sv
  - verilog/aes_192_top.sv
  - target: test
    files:
      - verification/aes_192_tb.sv

// File: verification/aes_192_tb.sv
`timescale 1ns/1ns

module aes_192_tb;
    import aes_stream_pkg::*;

    localparam int MAX_WORDS = 64;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    aes_req_t      req;
    logic          word_valid;
    aes_word_t     word;
    logic          overflow;

    // Count and burst length come first, then key, plaintext and ciphertext per vector
    logic [191:0]  stim [MAX_WORDS];
    logic [127:0]  exp_q [$];
    int            num_vec;
    int            burst_len;
    int            seed;
    int            errors;
    int            passes;
    int            blocks_seen;
    int            frame_errors;
    int            dropped;
    bit            allow_drops;
    int            pos;
    logic [127:0]  got;

    aes_192_top u_aes_192_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .req        (req),
        .word_valid (word_valid),
        .word       (word),
        .overflow   (overflow)
    );

    always #4 clk = ~clk;

    task automatic check_value(input logic [127:0] got_val, input logic [127:0] exp_val,
                               input string msg, output bit ok);
        ok = (got_val === exp_val);
        if (ok)
            passes++;
        else
        begin
            errors++;
            $display("Error at %0t ns: %s, got %h, expected %h", $time, msg, got_val, exp_val);
        end
    endtask

    task automatic report_test(input string name, input int n_err);
        if (n_err == 0)
            $display("%s: ok", name);
        else
            $display("%s: failed with %0d errors", name, n_err);
    endtask

    // In drop mode older pending entries may be skipped but never reordered
    task automatic match_block(input logic [127:0] blk);
        int hit;
        bit ok;
        hit = 0;
        if (allow_drops)
        begin
            while (hit < exp_q.size() - 1 && exp_q[hit] !== blk)
                hit++;
        end
        if (exp_q.size() == 0)
        begin
            errors++;
            $display("Output block %h at %0t ns arrived with no request pending", blk, $time);
        end
        else
        begin
            check_value(blk, exp_q[hit], "ciphertext block", ok);
            dropped += hit;
            for (int i = 0; i <= hit; i++)
                exp_q.delete(0);
        end
    endtask

    // ------------------------------------------------------------------------
    // Output monitor that assembles four words per block with the high word first
    // ------------------------------------------------------------------------
    always @(negedge clk)
    begin : monitor
        bit ok;
        if (!rst_n)
            pos = 0;
        else if (word_valid)
        begin
            check_value(word.last, pos == 3, "last flag on output word", ok);
            if (!ok)
                frame_errors++;
            got = {got[95:0], word.data};
            if (pos == 3)
            begin
                pos = 0;
                blocks_seen++;
                match_block(got);
            end
            else
                pos++;
        end
        else if (pos != 0)
        begin
            check_value(word_valid, 1'b1, "word_valid dropped inside a block", ok);
            frame_errors++;
            pos = 0;
        end
    end

    task automatic send_vector(input int v);
        @(posedge clk);
        in_valid <= 1'b1;
        req.key  <= aes_key192_t'(stim[2 + 3*v]);
        req.text <= aes_block_t'(stim[3 + 3*v][127:0]);
        exp_q.push_back(stim[4 + 3*v][127:0]);
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // Let the pipeline empty, then wait until the serializer stays silent
    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        repeat (16) @(posedge clk);
        while (quiet < 6)
        begin
            @(negedge clk);
            if (word_valid || pos != 0)
                quiet = 0;
            else
                quiet++;
        end
    endtask

    task automatic apply_reset();
        bit ok;
        @(posedge clk);
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            check_value(word_valid, 1'b0, "word_valid during reset", ok);
            check_value(overflow, 1'b0, "overflow during reset", ok);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value(word_valid, 1'b0, "word_valid after reset", ok);
        check_value(overflow, 1'b0, "overflow after reset", ok);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial
    begin : main
        int e0;
        int gap;
        int reset_errs;
        bit ok;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        req          = '0;
        seed         = 68;
        errors       = 0;
        passes       = 0;
        blocks_seen  = 0;
        frame_errors = 0;
        dropped      = 0;
        allow_drops  = 1'b0;
        $readmemh("verification/aes_192_stimulus.txt", stim);
        num_vec   = stim[0];
        burst_len = stim[1];
        if (num_vec < 4 || 2 + 3*num_vec > MAX_WORDS)
        begin
            $display("Stimulus file is missing or holds fewer than four vectors");
            $display("TEST RESULT: FAIL");
        end
        else
        begin
            apply_reset();
            reset_errs = errors;

            e0 = errors;
            send_vector(0);
            idle(1);
            wait_quiet();
            check_value(exp_q.size(), 0, "blocks missing after FIPS-197 vector", ok);
            report_test("Test 1 FIPS-197 vector", errors - e0);

            e0 = errors;
            for (int v = 0; v < num_vec; v++)
            begin
                send_vector(v);
                gap = 5 + $unsigned($random(seed)) % 4;
                idle(gap);
            end
            wait_quiet();
            check_value(exp_q.size(), 0, "blocks missing after spaced vectors", ok);
            check_value(overflow, 1'b0, "overflow after spaced vectors", ok);
            report_test("Test 2 spaced file vectors", errors - e0);

            // Four in a row fit in the FIFO while the serializer drains
            e0 = errors;
            for (int v = 0; v < 4; v++)
                send_vector(v % num_vec);
            idle(1);
            wait_quiet();
            check_value(exp_q.size(), 0, "blocks missing after four back to back", ok);
            check_value(overflow, 1'b0, "overflow after four back to back", ok);
            report_test("Test 4 four blocks in flight", errors - e0);

            e0 = errors;
            allow_drops = 1'b1;
            dropped     = 0;
            for (int i = 0; i < burst_len; i++)
                send_vector(i % num_vec);
            idle(1);
            wait_quiet();
            check_value(overflow, 1'b1, "overflow after long burst", ok);
            dropped += exp_q.size();
            exp_q.delete();
            check_value(dropped > 0, 1'b1, "no block dropped in long burst", ok);
            allow_drops = 1'b0;
            report_test($sformatf("Test 5 burst of %0d, %0d dropped", burst_len, dropped),
                        errors - e0);

            report_test($sformatf("Test 3 word framing over %0d blocks", blocks_seen),
                        frame_errors);

            e0 = errors;
            apply_reset();
            report_test("Test 6 reset levels and overflow clear", reset_errs + errors - e0);

            $display("Checks passed: %0d, errors: %0d", passes, errors);
            if (errors == 0)
                $display("TEST RESULT: PASS");
            else
                $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Budget covers three passes over the vectors, the burst and the drains
    initial
    begin : watchdog
        int limit;
        #1;
        limit = num_vec * 25 + burst_len * 5 + 200;
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles, the DUT stopped producing words", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog/aes_192_top.sv
`timescale 1ns/1ns

module aes_192_top
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  aes_stream_pkg::aes_req_t  req,
    output logic                      word_valid,
    output aes_stream_pkg::aes_word_t word,
    output logic                      overflow
);
    import aes_stream_pkg::*;

    logic       blk_valid;
    aes_block_t blk;
    aes_block_t head;
    logic       empty;
    logic       pop;

    aes_192_pipe u_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .blk_valid (blk_valid),
        .blk       (blk)
    );

    // Blocks that find the FIFO full are dropped here
    aes_result_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (blk_valid),
        .wr_data  (blk),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .overflow (overflow)
    );

    aes_word_serializer u_ser (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty      (empty),
        .head       (head),
        .pop        (pop),
        .word_valid (word_valid),
        .word       (word)
    );

endmodule

// File: verilog/aes_word_serializer.sv
`timescale 1ns/1ns

module aes_word_serializer
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       empty,
    input  aes_stream_pkg::aes_block_t head,
    output logic                       pop,
    output logic                       word_valid,
    output aes_stream_pkg::aes_word_t  word
);
    import aes_stream_pkg::*;

    ser_state_e ser_state;
    logic [1:0] idx;
    aes_block_t held;

    // Pop and capture in the same cycle
    assign pop        = (ser_state == SER_IDLE) && !empty;
    assign word_valid = (ser_state == SER_SEND);
    assign word.data  = held.w[idx];
    assign word.last  = (idx == 2'd0);

    always_ff @(posedge clk)
    begin
        if (pop)
            held <= head;
    end

    // ------------------------------------------------------------------------
    // Four words per block, high word first
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ser_state <= SER_IDLE;
            idx       <= 2'd3;
        end
        else
        begin
            case (ser_state)
                SER_IDLE:
                begin
                    idx <= 2'd3;
                    if (!empty)
                        ser_state <= SER_SEND;
                end
                default:
                begin
                    if (idx == 2'd0)
                        ser_state <= SER_IDLE;
                    else
                        idx <= idx - 2'd1;
                end
            endcase
        end
    end

endmodule

// File: verilog/aes_result_fifo.sv
`timescale 1ns/1ns

module aes_result_fifo
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr,
    input  aes_stream_pkg::aes_block_t wr_data,
    input  logic                       pop,
    output aes_stream_pkg::aes_block_t head,
    output logic                       empty,
    output logic                       overflow
);
    import aes_stream_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    aes_block_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_wr;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full   = (count == CNT_W'(FIFO_DEPTH));
    assign empty  = (count == '0);
    // A write into a full FIFO is lost even when a pop happens alongside
    assign do_wr  = wr & ~full;
    assign do_pop = pop & ~empty;
    assign head   = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            if (do_wr && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_wr)
                count <= count - 1'b1;
            // Sticky until reset
            if (wr && full)
                overflow <= 1'b1;
        end
    end

endmodule

// File: verilog/aes_192_pipe.sv
`timescale 1ns/1ns

module aes_192_pipe
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  aes_stream_pkg::aes_req_t   req,
    output logic                       blk_valid,
    output aes_stream_pkg::aes_block_t blk
);
    import aes_math_pkg::*;
    import aes_stream_pkg::*;

    localparam int ROUNDS  = 12;
    localparam int LATENCY = ROUNDS + 1;

    // Key stage kind and rcon index for each round
    localparam key_stage_e STAGE_KINDS [ROUNDS] = '{
        KEY_STAGE_D, KEY_STAGE_B, KEY_STAGE_A, KEY_STAGE_C,
        KEY_STAGE_B, KEY_STAGE_A, KEY_STAGE_C, KEY_STAGE_B,
        KEY_STAGE_A, KEY_STAGE_C, KEY_STAGE_B, KEY_STAGE_A
    };
    localparam int RCON_IDXS [ROUNDS] = '{0, 0, 1, 2, 0, 3, 4, 0, 5, 6, 0, 7};

    aes_block_t    state     [ROUNDS + 1];
    aes_key192_t   key_chain [ROUNDS];
    aes_block_t    round_key [ROUNDS];
    logic [LATENCY-1:0] valid_sr;

    // Input register with the initial AddRoundKey (key words 0 to 3)
    always_ff @(posedge clk)
    begin
        state[0]     <= req.text ^ req.key.w[5:2];
        key_chain[0] <= req.key;
    end

    // ------------------------------------------------------------------------
    // Key stages and rounds, one cycle each and in lock step
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < ROUNDS; i++)
    begin : g_stage
        if (i < ROUNDS - 1)
        begin : g_key
            aes_key_expand_192 #(
                .STAGE_KIND (STAGE_KINDS[i]),
                .RCON_IDX   (RCON_IDXS[i])
            ) u_key (
                .clk       (clk),
                .rst_n     (rst_n),
                .key_in    (key_chain[i]),
                .key_out   (key_chain[i + 1]),
                .round_key (round_key[i])
            );
        end
        else
        begin : g_key_last
            // Final key stage feeds no further stage
            aes_key_expand_192 #(
                .STAGE_KIND (STAGE_KINDS[i]),
                .RCON_IDX   (RCON_IDXS[i])
            ) u_key (
                .clk       (clk),
                .rst_n     (rst_n),
                .key_in    (key_chain[i]),
                .key_out   (),
                .round_key (round_key[i])
            );
        end

        aes_round #(
            .LAST_ROUND (i == ROUNDS - 1)
        ) u_round (
            .clk       (clk),
            .rst_n     (rst_n),
            .state_in  (state[i]),
            .round_key (round_key[i]),
            .state_out (state[i + 1])
        );
    end

    // Valid travels beside the data
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_sr <= '0;
        else
            valid_sr <= {valid_sr[LATENCY-2:0], in_valid};
    end

    assign blk_valid = valid_sr[LATENCY-1];
    assign blk       = state[ROUNDS];

endmodule

// File: verilog/aes_round.sv
`timescale 1ns/1ns

module aes_round
#(
    parameter bit LAST_ROUND = 1'b0
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  aes_stream_pkg::aes_block_t state_in,
    input  aes_stream_pkg::aes_block_t round_key,
    output aes_stream_pkg::aes_block_t state_out
);
    import aes_math_pkg::*;

    // Byte n sits in row n%4 of column n/4
    logic [7:0]   sb [16];
    logic [7:0]   sr [16];
    logic [7:0]   mc [16];
    logic [127:0] mixed;

    // SubBytes and ShiftRows
    always_comb
    begin
        for (int n = 0; n < 16; n++)
            sb[n] = sub_byte(state_in[127 - 8*n -: 8]);
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                sr[4*c + r] = sb[4*((c + r) % 4) + r];
        end
    end

    // ------------------------------------------------------------------------
    // MixColumns, skipped in the final round
    // ------------------------------------------------------------------------
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            if (LAST_ROUND)
            begin
                for (int r = 0; r < 4; r++)
                    mc[4*c + r] = sr[4*c + r];
            end
            else
            begin
                mc[4*c]     = xtime(sr[4*c]) ^ xtime(sr[4*c+1]) ^ sr[4*c+1]
                              ^ sr[4*c+2] ^ sr[4*c+3];
                mc[4*c + 1] = sr[4*c] ^ xtime(sr[4*c+1]) ^ xtime(sr[4*c+2])
                              ^ sr[4*c+2] ^ sr[4*c+3];
                mc[4*c + 2] = sr[4*c] ^ sr[4*c+1] ^ xtime(sr[4*c+2])
                              ^ xtime(sr[4*c+3]) ^ sr[4*c+3];
                mc[4*c + 3] = xtime(sr[4*c]) ^ sr[4*c] ^ sr[4*c+1]
                              ^ sr[4*c+2] ^ xtime(sr[4*c+3]);
            end
        end
        for (int n = 0; n < 16; n++)
            mixed[127 - 8*n -: 8] = mc[n];
    end

    // AddRoundKey into the round register
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_out <= '0;
        else
            state_out <= mixed ^ round_key;
    end

endmodule

// File: verilog/aes_key_expand_192.sv
`timescale 1ns/1ns

module aes_key_expand_192
#(
    parameter aes_math_pkg::key_stage_e STAGE_KIND = aes_math_pkg::KEY_STAGE_B,
    parameter int                       RCON_IDX   = 0
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  aes_stream_pkg::aes_key192_t key_in,
    output aes_stream_pkg::aes_key192_t key_out,
    output aes_stream_pkg::aes_block_t  round_key
);
    import aes_math_pkg::*;

    localparam rcon_t RCON = rcon_table(RCON_IDX);

    // Position of the first round key word in the six word window
    localparam int RK_FIRST = (STAGE_KIND == KEY_STAGE_A) ? 0 :
                              (STAGE_KIND == KEY_STAGE_B) ? 2 : 4;

    // Window words in FIPS order, k[0] is the oldest word
    logic [31:0] k [6];
    logic [31:0] n [6];
    logic [31:0] t;

    function automatic logic [31:0] rot_sub_word(input logic [31:0] x);
        logic [31:0] r;
        r = {x[23:0], x[31:24]};
        return {sub_byte(r[31:24]), sub_byte(r[23:16]), sub_byte(r[15:8]), sub_byte(r[7:0])};
    endfunction

    // ------------------------------------------------------------------------
    // Next window, four new words per stage
    // ------------------------------------------------------------------------
    always_comb
    begin
        for (int j = 0; j < 6; j++)
        begin
            k[j] = key_in.w[5 - j];
            n[j] = k[j];
        end
        t = 32'h0;
        case (STAGE_KIND)
            KEY_STAGE_D:
            begin
                t    = rot_sub_word(k[5]) ^ {RCON, 24'h0};
                n[0] = k[0] ^ t;
                n[1] = n[0] ^ k[1];
            end
            KEY_STAGE_A:
            begin
                t    = rot_sub_word(k[5]) ^ {RCON, 24'h0};
                n[0] = k[0] ^ t;
                n[1] = n[0] ^ k[1];
                n[2] = n[1] ^ k[2];
                n[3] = n[2] ^ k[3];
            end
            KEY_STAGE_B:
            begin
                // No SubWord here, the chain only runs XORs
                n[2] = k[1] ^ k[2];
                n[3] = n[2] ^ k[3];
                n[4] = n[3] ^ k[4];
                n[5] = n[4] ^ k[5];
            end
            default:
            begin
                // Kind C wraps around, the rcon step uses the fresh word 5
                n[4] = k[3] ^ k[4];
                n[5] = n[4] ^ k[5];
                t    = rot_sub_word(n[5]) ^ {RCON, 24'h0};
                n[0] = k[0] ^ t;
                n[1] = n[0] ^ k[1];
            end
        endcase
    end

    // Round key for the data round running in this cycle
    always_comb
    begin
        for (int j = 0; j < 4; j++)
            round_key.w[3 - j] = n[(RK_FIRST + j) % 6];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            key_out <= '0;
        else
        begin
            for (int j = 0; j < 6; j++)
                key_out.w[5 - j] <= n[j];
        end
    end

endmodule

// File: verilog/aes_stream_pkg.sv
package aes_stream_pkg;

    // ------------------------------------------------------------------------
    // Data carried between the pipeline, the FIFO and the serializer
    // ------------------------------------------------------------------------

    // 128-bit state, w[3] is the most significant word (AES column 0)
    typedef struct packed {
        logic [3:0][31:0] w;
    } aes_block_t;

    // 192-bit key, w[5] is the most significant word (FIPS word 0)
    typedef struct packed {
        logic [5:0][31:0] w;
    } aes_key192_t;

    // Pipeline input, plaintext and key arrive together
    typedef struct packed {
        aes_block_t  text;
        aes_key192_t key;
    } aes_req_t;

    // One output word, last marks the fourth word of a block
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } aes_word_t;

    typedef enum logic
    {
        SER_IDLE,
        SER_SEND
    } ser_state_e;

endpackage

// File: verilog/aes_math_pkg.sv
package aes_math_pkg;

    // Round constant byte, applied to the top byte of a key word
    typedef logic [7:0] rcon_t;

    // Key schedule stage kinds, D is used once at the head of the chain
    typedef enum logic [1:0]
    {
        KEY_STAGE_D,
        KEY_STAGE_A,
        KEY_STAGE_B,
        KEY_STAGE_C
    } key_stage_e;

    // ------------------------------------------------------------------------
    // GF(2^8) arithmetic with the AES polynomial x^8 + x^4 + x^3 + x + 1
    // ------------------------------------------------------------------------

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p ^= x;
            x = xtime(x);
        end
        return p;
    endfunction

    // Inverse as b^254, zero maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] b);
        logic [7:0] sq;
        logic [7:0] acc;
        sq  = b;
        acc = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // Forward S-box: inversion followed by the affine map
    function automatic logic [7:0] sub_byte(input logic [7:0] b);
        logic [7:0] inv;
        inv = gf_inv(b);
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    // Index 0 gives 01, index 7 gives 80
    function automatic rcon_t rcon_table(input int unsigned idx);
        return rcon_t'(8'h01 << idx);
    endfunction

endpackage
